//--- Bender.yml
package:
  name: fp_unit

sources:
  - fp_pkg.sv
  - fp_mul.sv
  - fp_add.sv
  - fp_invsqrt.sv
  - fp_int_to_float.sv
  - fp_float_to_int.sv
  - fp_unit.sv
  - target: test
    files:
      - fp_unit_sva.sv
      - tb_fp_unit.sv

//--- fp_add.sv
`timescale 1ns/10ps

module fp_add import fp_pkg::*; (
	input  logic     iCLK,
	input  float27_t a,
	input  float27_t b,
	output float27_t sum
);

	// Operand fields
	logic        sign_a;
	logic        sign_b;
	fp_exp_t     exp_a;
	fp_exp_t     exp_b;
	fp_frac_t    frac_a;
	fp_frac_t    frac_b;
	// Extended significands, hidden one at bit 35, carry room at 36
	logic [36:0] ext_a;
	logic [36:0] ext_b;
	logic        a_larger;
	fp_exp_t     big_exp;
	fp_exp_t     exp_diff;
	logic [36:0] big_ext;
	logic [36:0] small_ext;
	logic [36:0] small_aligned;
	logic [36:0] pre_sum;

	// Stage one registers
	logic [36:0] sum_q;
	fp_exp_t     big_exp_q;
	logic        sign_q;
	logic        a_zero_q;
	logic        b_zero_q;
	float27_t    a_q;
	float27_t    b_q;

	// Stage two normalization
	logic [5:0]  lead_shift;
	logic [36:0] norm;
	logic [9:0]  exp_wide;
	logic        underflow;

	assign sign_a = a[26];
	assign sign_b = b[26];
	assign exp_a  = a[25:18];
	assign exp_b  = b[25:18];
	assign frac_a = a[17:0];
	assign frac_b = b[17:0];
	assign ext_a  = {1'b0, 1'b1, frac_a, 17'b0};
	assign ext_b  = {1'b0, 1'b1, frac_b, 17'b0};

	// ==============================
	// Stage one: align and add
	// ==============================

	// Larger magnitude decides sign and exponent
	assign a_larger = (exp_a > exp_b) || ((exp_a == exp_b) && (frac_a > frac_b));
	assign big_exp   = a_larger ? exp_a : exp_b;
	assign exp_diff  = a_larger ? (exp_a - exp_b) : (exp_b - exp_a);
	assign big_ext   = a_larger ? ext_a : ext_b;
	assign small_ext = a_larger ? ext_b : ext_a;

	// Smaller operand shifted out entirely past 35 places
	assign small_aligned = (exp_diff > 8'd35) ? '0 : (small_ext >> exp_diff);

	// Opposite signs subtract, never goes negative
	assign pre_sum = (sign_a ^ sign_b) ? (big_ext - small_aligned) : (big_ext + small_aligned);

	always_ff @(posedge iCLK) begin
		sum_q     <= pre_sum;
		big_exp_q <= big_exp;
		sign_q    <= a_larger ? sign_a : sign_b;
		a_zero_q  <= (exp_a == '0);
		b_zero_q  <= (exp_b == '0);
		a_q       <= a;
		b_q       <= b;
	end

	// ==============================
	// Stage two: renormalize
	// ==============================

	// Leading one position counted down from bit 36
	always_comb begin
		lead_shift = 6'd37;
		for (int i = 0; i < 37; i++) begin
			if (sum_q[i]) begin
				lead_shift = 6'(36 - i);
			end
		end
	end

	// Leading one moved to bit 36, fraction just below it
	assign norm = sum_q << lead_shift;

	// Carry into bit 36 raises the exponent by one
	assign exp_wide  = {2'b00, big_exp_q} + 10'd1 - {4'd0, lead_shift};
	// Negative or zero exponent is underflow
	assign underflow = exp_wide[9] || (exp_wide == '0);

	always_ff @(posedge iCLK) begin
		if (a_zero_q && b_zero_q) begin
			sum <= '0;
		end else if (a_zero_q) begin
			sum <= b_q;
		end else if (b_zero_q) begin
			sum <= a_q;
		end else if (underflow || sum_q == '0) begin
			// Exact cancellation lands here too
			sum <= '0;
		end else begin
			sum <= {sign_q, exp_wide[7:0], norm[35:18]};
		end
	end

endmodule

//--- fp_float_to_int.sv
`timescale 1ns/10ps

module fp_float_to_int import fp_pkg::*; (
	input  float27_t value,
	output fp_int_t  int_out
);

	logic        sign;
	fp_exp_t     exp_in;
	fp_exp_t     shift;
	logic [33:0] wide;
	fp_int_t     mag;

	assign sign   = value[26];
	assign exp_in = value[25:18];

	// Restored significand, integer part starts at bit 18
	assign shift = exp_in - FP_BIAS;
	assign wide  = {15'b0, 1'b1, value[17:0]} << shift[3:0];
	// Truncation toward zero
	assign mag   = wide[33:18];

	always_comb begin
		if (exp_in < FP_BIAS) begin
			// Magnitude below one
			int_out = '0;
		end else if (exp_in > FP_BIAS + 8'd14) begin
			// Saturate symmetric
			int_out = sign ? -FP_INT_MAX : FP_INT_MAX;
		end else begin
			int_out = sign ? -mag : mag;
		end
	end

endmodule

//--- fp_int_to_float.sv
`timescale 1ns/10ps

module fp_int_to_float import fp_pkg::*; (
	input  fp_int_t  int_in,
	output float27_t value
);

	// Magnitude, -32768 still fits as unsigned
	logic [15:0] mag;
	logic [3:0]  lead_pos;
	logic [33:0] norm;
	fp_exp_t     exp_out;

	assign mag = int_in[15] ? -int_in : int_in;

	// Priority encoder, highest set bit wins
	always_comb begin
		lead_pos = 4'd0;
		for (int i = 0; i < 16; i++) begin
			if (mag[i]) begin
				lead_pos = 4'(i);
			end
		end
	end

	// Leading one lands on bit 18, just above the fraction
	assign norm    = {mag, 18'b0} >> lead_pos;
	assign exp_out = FP_BIAS + {4'd0, lead_pos};

	// Zero has an all-zero encoding
	assign value = (int_in == '0) ? '0 : {int_in[15], exp_out, norm[17:0]};

endmodule

//--- fp_invsqrt.sv
`timescale 1ns/10ps

module fp_invsqrt import fp_pkg::*; (
	input  logic     iCLK,
	input  float27_t a,
	output float27_t inv_sqrt
);

	// Stage 1: seed and half operand
	float27_t seed;
	float27_t half_a;
	float27_t seed_sq;
	// Stage 2
	float27_t seed_2;
	float27_t seed_sq_2;
	float27_t half_a_2;
	float27_t prod_2;
	// Stage 3: into the adder
	float27_t seed_3;
	float27_t prod_3;
	float27_t corr;
	// Seed riding alongside the adder stages
	float27_t seed_d [FP_ADD_LATENCY];
	// Stage 5: final multiply operands
	float27_t seed_5;
	float27_t corr_5;

	// Integer trick on the raw bits
	assign seed   = FP_INVSQRT_MAGIC - (a >> 1);
	// Halving by exponent decrement
	assign half_a = {a[26], a[25:18] - 8'd1, a[17:0]};

	// y * y
	fp_mul mul_sq_inst (
		.a    (seed),
		.b    (seed),
		.prod (seed_sq)
	);

	// (x / 2) * y * y
	fp_mul mul_half_inst (
		.a    (half_a_2),
		.b    (seed_sq_2),
		.prod (prod_2)
	);

	// 1.5 - (x / 2) * y * y, sign flipped on the product
	fp_add add_corr_inst (
		.iCLK (iCLK),
		.a    ({~prod_3[26], prod_3[25:0]}),
		.b    (FP_THREE_HALVES),
		.sum  (corr)
	);

	// Newton step result
	fp_mul mul_out_inst (
		.a    (seed_5),
		.b    (corr_5),
		.prod (inv_sqrt)
	);

	// Pipeline registers, one item per stage
	always_ff @(posedge iCLK) begin
		seed_2    <= seed;
		seed_sq_2 <= seed_sq;
		half_a_2  <= half_a;
		seed_3    <= seed_2;
		prod_3    <= prod_2;
		seed_d[0] <= seed_3;
		for (int i = 1; i < FP_ADD_LATENCY; i++) begin
			seed_d[i] <= seed_d[i - 1];
		end
		seed_5    <= seed_d[FP_ADD_LATENCY - 1];
		corr_5    <= corr;
	end

endmodule

//--- fp_mul.sv
`timescale 1ns/10ps

module fp_mul import fp_pkg::*; (
	input  float27_t a,
	input  float27_t b,
	output float27_t prod
);

	// Operand fields
	logic        sign_a;
	logic        sign_b;
	fp_exp_t     exp_a;
	fp_exp_t     exp_b;
	// Top 18 bits of each significand, hidden one restored
	logic [17:0] sig_a;
	logic [17:0] sig_b;
	// Raw product and exponent sum
	logic [35:0] sig_prod;
	logic [8:0]  exp_sum;
	logic [8:0]  exp_norm;
	fp_frac_t    frac_out;
	logic        underflow;

	assign sign_a = a[26];
	assign sign_b = b[26];
	assign exp_a  = a[25:18];
	assign exp_b  = b[25:18];
	assign sig_a  = {1'b1, a[17:1]};
	assign sig_b  = {1'b1, b[17:1]};

	assign sig_prod = sig_a * sig_b;
	assign exp_sum  = {1'b0, exp_a} + {1'b0, exp_b};

	// Product lies in [1,4)
	// top bit set means one place more of exponent
	assign exp_norm = exp_sum - {1'b0, FP_BIAS} + {8'd0, sig_prod[35]};
	assign frac_out = sig_prod[35] ? sig_prod[34:17] : sig_prod[33:16];

	// Sum at or below the bias leaves no valid exponent
	assign underflow = (exp_sum <= {1'b0, FP_BIAS});

	// Zero operand or underflow gives zero
	assign prod = (underflow || exp_a == '0 || exp_b == '0) ? '0 :
		{sign_a ^ sign_b, exp_norm[7:0], frac_out};

endmodule

//--- fp_pkg.sv
package fp_pkg;

	// ==============================
	// Number format
	// ==============================

	// One value: sign, biased exponent, stored fraction
	typedef logic [26:0] float27_t;

	// Biased exponent field, zero means the value is zero
	typedef logic [7:0] fp_exp_t;

	// Stored fraction, hidden leading one not kept
	typedef logic [17:0] fp_frac_t;

	// Signed integer operand or result
	typedef logic signed [15:0] fp_int_t;

	// Operation codes of the unit
	typedef enum logic [2:0] {
		OP_ADD      = 3'd0,
		OP_MUL      = 3'd1,
		OP_INVSQRT  = 3'd2,
		OP_FROM_INT = 3'd3,
		OP_TO_INT   = 3'd4
	} fp_op_t;

	// ==============================
	// Arithmetic constants
	// ==============================

	// Exponent of the value one
	localparam fp_exp_t FP_BIAS = 8'd127;
	// Seed constant of the fast inverse square root
	localparam float27_t FP_INVSQRT_MAGIC = 27'd49920718;
	// 1.5 in the format
	localparam float27_t FP_THREE_HALVES = 27'd33423360;
	// Saturation magnitude of integer results
	localparam fp_int_t FP_INT_MAX = 16'sd32767;

	// Pipeline depths in cycles
	localparam int FP_ADD_LATENCY     = 2;
	localparam int FP_INVSQRT_LATENCY = 5;
	localparam int FP_UNIT_LATENCY    = 6;

endpackage

//--- fp_unit.sv
`timescale 1ns/10ps

module fp_unit import fp_pkg::*; (
	input  logic     iCLK,
	input  logic     reset_key,
	input  logic     in_valid,
	input  fp_op_t   op,
	input  float27_t a,
	input  float27_t b,
	input  fp_int_t  int_in,
	output logic     out_valid,
	output float27_t result,
	output fp_int_t  int_result
);

	// Stages ahead of the output register
	localparam int COMB_DEPTH = FP_UNIT_LATENCY - 1;
	// Extra stages after the adder
	localparam int ADD_DEPTH = FP_UNIT_LATENCY - 1 - FP_ADD_LATENCY;

	// Sub-unit results
	float27_t add_sum;
	float27_t mul_prod;
	float27_t inv_sqrt_out;
	float27_t itof_value;
	fp_int_t  ftoi_value;

	// Alignment delay lines
	float27_t mul_d  [COMB_DEPTH];
	float27_t itof_d [COMB_DEPTH];
	fp_int_t  ftoi_d [COMB_DEPTH];
	float27_t add_d  [ADD_DEPTH];
	fp_op_t   op_d   [COMB_DEPTH];
	logic [COMB_DEPTH-1:0] valid_d;

	// ==============================
	// Arithmetic units
	// ==============================

	fp_add add_inst (
		.iCLK (iCLK),
		.a    (a),
		.b    (b),
		.sum  (add_sum)
	);

	fp_mul mul_inst (
		.a    (a),
		.b    (b),
		.prod (mul_prod)
	);

	fp_invsqrt invsqrt_inst (
		.iCLK     (iCLK),
		.a        (a),
		.inv_sqrt (inv_sqrt_out)
	);

	fp_int_to_float itof_inst (
		.int_in (int_in),
		.value  (itof_value)
	);

	fp_float_to_int ftoi_inst (
		.value   (a),
		.int_out (ftoi_value)
	);

	// Valid line, the only reset state
	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			valid_d   <= '0;
			out_valid <= 1'b0;
		end else begin
			valid_d   <= {valid_d[COMB_DEPTH-2:0], in_valid};
			out_valid <= valid_d[COMB_DEPTH-1];
		end
	end

	// Data and op code lines
	always_ff @(posedge iCLK) begin
		mul_d[0]  <= mul_prod;
		itof_d[0] <= itof_value;
		ftoi_d[0] <= ftoi_value;
		op_d[0]   <= op;
		for (int i = 1; i < COMB_DEPTH; i++) begin
			mul_d[i]  <= mul_d[i - 1];
			itof_d[i] <= itof_d[i - 1];
			ftoi_d[i] <= ftoi_d[i - 1];
			op_d[i]   <= op_d[i - 1];
		end
		// Adder output already two stages in
		add_d[0] <= add_sum;
		for (int i = 1; i < ADD_DEPTH; i++) begin
			add_d[i] <= add_d[i - 1];
		end
	end

	// ==============================
	// Output selection
	// ==============================

	always_ff @(posedge iCLK) begin
		result     <= '0;
		int_result <= '0;
		case (op_d[COMB_DEPTH-1])
			OP_ADD:      result <= add_d[ADD_DEPTH-1];
			OP_MUL:      result <= mul_d[COMB_DEPTH-1];
			OP_INVSQRT:  result <= inv_sqrt_out;
			OP_FROM_INT: result <= itof_d[COMB_DEPTH-1];
			// Integer answer on its own port
			OP_TO_INT:   int_result <= ftoi_d[COMB_DEPTH-1];
			default:     result <= '0;
		endcase
	end

endmodule

//--- fp_unit_sva.sv
`timescale 1ns/10ps

module fp_unit_sva import fp_pkg::*; (
	input logic   iCLK,
	input logic   reset_key,
	input logic   in_valid,
	input fp_op_t op,
	input logic   out_valid
);

	// Number of failed properties
	int assert_errors = 0;

	// Valid line cleared by reset
	assert property (@(posedge iCLK) reset_key |=> !out_valid)
		else begin
			assert_errors++;
			$error("out_valid high during reset");
		end

	// Every result has its request
	assert property (@(posedge iCLK) disable iff (reset_key)
		out_valid |-> $past(in_valid, FP_UNIT_LATENCY))
		else begin
			assert_errors++;
			$error("out_valid without a request");
		end

	// Every request gets its result
	assert property (@(posedge iCLK) disable iff (reset_key)
		in_valid |-> ##FP_UNIT_LATENCY out_valid)
		else begin
			assert_errors++;
			$error("request without a result");
		end

	assert property (@(posedge iCLK) in_valid |-> !$isunknown(op))
		else begin
			assert_errors++;
			$error("op unknown on a request");
		end

endmodule

bind fp_unit fp_unit_sva fp_unit_sva_inst (
	.iCLK      (iCLK),
	.reset_key (reset_key),
	.in_valid  (in_valid),
	.op        (op),
	.out_valid (out_valid)
);

//--- tb.f
fp_pkg.sv
fp_mul.sv
fp_add.sv
fp_invsqrt.sv
fp_int_to_float.sv
fp_float_to_int.sv
fp_unit.sv
fp_unit_sva.sv
tb_fp_unit.sv

//--- tb_fp_unit.sv
`timescale 1ns/10ps

module tb_fp_unit import fp_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;
	// Kinds of expected answers
	localparam int KIND_FLOAT  = 0;
	localparam int KIND_INT    = 1;
	localparam int KIND_APPROX = 2;

	logic     iCLK = 1'b0;
	logic     reset_key;
	logic     in_valid;
	fp_op_t   op;
	float27_t a;
	float27_t b;
	fp_int_t  int_in;
	logic     out_valid;
	float27_t result;
	fp_int_t  int_result;

	integer seed;
	int     cycle_count = 0;
	int     checks = 0;
	int     value_errors = 0;
	int     other_errors = 0;

	// Expected answers in request order
	int       due_q[$];
	int       kind_q[$];
	float27_t float_q[$];
	fp_int_t  int_q[$];
	real      real_q[$];

	fp_unit fp_unit_inst (
		.iCLK       (iCLK),
		.reset_key  (reset_key),
		.in_valid   (in_valid),
		.op         (op),
		.a          (a),
		.b          (b),
		.int_in     (int_in),
		.out_valid  (out_valid),
		.result     (result),
		.int_result (int_result)
	);

	// 8 ns period
	always #4 iCLK = ~iCLK;

	// Cycle count and run limit
	always @(posedge iCLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, results still outstanding", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ==============================
	// Format model
	// ==============================

	// Exponent zero is the value zero, else 1.frac times 2^(exp-127)
	function automatic real decode_float(input float27_t f);
		real m;
		int  e;
		if (f[25:18] == 8'd0) begin
			return 0.0;
		end
		m = 1.0 + real'(f[17:0]) / 262144.0;
		for (e = int'(f[25:18]) - 127; e > 0; e--) begin
			m = m * 2.0;
		end
		while (e < 0) begin
			m = m / 2.0;
			e++;
		end
		return f[26] ? -m : m;
	endfunction

	// Truncating encoder, exact for short fractions
	function automatic float27_t encode_real(input real r);
		real  m;
		int   e;
		logic s;
		if (r == 0.0) begin
			return '0;
		end
		s = (r < 0.0);
		m = s ? -r : r;
		e = 0;
		while (m >= 2.0) begin
			m = m / 2.0;
			e++;
		end
		while (m < 1.0) begin
			m = m * 2.0;
			e--;
		end
		return {s, 8'(e + 127), 18'($rtoi((m - 1.0) * 262144.0))};
	endfunction

	// Truncation toward zero, symmetric saturation
	function automatic fp_int_t expected_to_int(input real r);
		if (r >= 32768.0) begin
			return 16'sd32767;
		end
		if (r <= -32768.0) begin
			return -16'sd32767;
		end
		return fp_int_t'($rtoi(r));
	endfunction

	// Positive value over a moderate exponent range
	function automatic float27_t random_positive();
		logic [31:0] r;
		r = $random(seed);
		return {1'b0, 8'd112 + {3'd0, r[4:0]}, r[22:5]};
	endfunction

	// ==============================
	// Checking
	// ==============================

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic compare_output();
		int       due;
		int       kind;
		float27_t want_f;
		fp_int_t  want_i;
		real      want_r;
		real      diff;
		if (out_valid === 1'b1 && due_q.size() == 0) begin
			$display("out_valid went high at %0t ns with no request in flight", $time);
			other_errors++;
		end else if (out_valid === 1'b1) begin
			due    = due_q.pop_front();
			kind   = kind_q.pop_front();
			want_f = float_q.pop_front();
			want_i = int_q.pop_front();
			want_r = real_q.pop_front();
			check_value("out_valid cycle", due, cycle_count);
			if (kind == KIND_INT) begin
				check_value("int_result", {16'd0, want_i}, {16'd0, int_result});
			end else if (kind == KIND_FLOAT) begin
				check_value("result", {5'd0, want_f}, {5'd0, result});
			end else begin
				checks++;
				diff = decode_float(result) - want_r;
				if (diff < 0.0) begin
					diff = -diff;
				end
				if (diff > 0.01 * want_r) begin
					$display("Error at %0t ns: result expected %f, got %f",
						$time, want_r, decode_float(result));
					value_errors++;
				end
			end
		end else if (out_valid !== 1'b0) begin
			$display("out_valid is unknown at %0t ns", $time);
			other_errors++;
		end else if (due_q.size() > 0 && cycle_count >= due_q[0]) begin
			$display("No result came out for the request due in cycle %0d", due_q[0]);
			other_errors++;
			due    = due_q.pop_front();
			kind   = kind_q.pop_front();
			want_f = float_q.pop_front();
			want_i = int_q.pop_front();
			want_r = real_q.pop_front();
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge iCLK) begin
		if (reset_key && cycle_count > 0) begin
			check_value("out_valid", 32'd0, {31'd0, out_valid});
		end else if (!reset_key) begin
			compare_output();
		end
	end

	// ==============================
	// Stimulus
	// ==============================

	// One request, expected answer from the operation's rule
	task automatic send(input fp_op_t o, input float27_t x, input float27_t y, input fp_int_t n);
		real xr;
		real yr;
		xr = decode_float(x);
		yr = decode_float(y);
		@(posedge iCLK);
		#1;
		in_valid = 1'b1;
		op       = o;
		a        = x;
		b        = y;
		int_in   = n;
		due_q.push_back(cycle_count + 6);
		kind_q.push_back(o == OP_TO_INT ? KIND_INT : (o == OP_INVSQRT ? KIND_APPROX : KIND_FLOAT));
		float_q.push_back(o == OP_ADD ? encode_real(xr + yr) :
			(o == OP_MUL ? encode_real(xr * yr) : encode_real(real'(n))));
		int_q.push_back(expected_to_int(xr));
		real_q.push_back(o == OP_INVSQRT ? 1.0 / $sqrt(xr) : 0.0);
	endtask

	// Stop sending and wait for every result
	task automatic finish_batch();
		@(posedge iCLK);
		#1;
		in_valid = 1'b0;
		while (due_q.size() > 0) @(negedge iCLK);
	endtask

	task automatic test_reset_idle();
		repeat (2) @(posedge iCLK);
		#1;
		reset_key = 1'b0;
		// Monitor flags any out_valid here
		repeat (8) @(posedge iCLK);
	endtask

	task automatic test_int_conversion();
		int n;
		for (int i = 0; i < 45; i++) begin
			case (i)
				0: n = 0;
				1: n = 1;
				2: n = -1;
				3: n = 32767;
				4: n = -32767;
				default: n = $random(seed) % 32768;
			endcase
			send(OP_FROM_INT, '0, '0, fp_int_t'(n));
			send(OP_TO_INT, encode_real(real'(n)), '0, '0);
		end
		send(OP_TO_INT, encode_real(0.5), '0, '0);
		send(OP_TO_INT, encode_real(1048576.0), '0, '0);
		send(OP_TO_INT, encode_real(-1048576.0), '0, '0);
		finish_batch();
	endtask

	task automatic test_mul_add();
		send(OP_MUL, encode_real(2.0), encode_real(3.0), '0);
		send(OP_MUL, encode_real(-1.5), encode_real(4.0), '0);
		send(OP_ADD, encode_real(2.5), encode_real(3.25), '0);
		send(OP_ADD, encode_real(5.0), encode_real(-7.0), '0);
		send(OP_ADD, encode_real(3.375), encode_real(-3.375), '0);
		// Zero operands
		send(OP_MUL, '0, encode_real(7.5), '0);
		send(OP_MUL, encode_real(-7.5), '0, '0);
		send(OP_ADD, '0, encode_real(7.5), '0);
		send(OP_ADD, encode_real(-2.25), '0, '0);
		send(OP_ADD, '0, '0, '0);
		finish_batch();
	endtask

	task automatic test_invsqrt();
		send(OP_INVSQRT, encode_real(1.0), '0, '0);
		send(OP_INVSQRT, encode_real(2.0), '0, '0);
		send(OP_INVSQRT, encode_real(4.0), '0, '0);
		send(OP_INVSQRT, encode_real(100.0), '0, '0);
		send(OP_INVSQRT, encode_real(0.25), '0, '0);
		repeat (20) send(OP_INVSQRT, random_positive(), '0, '0);
		finish_batch();
	endtask

	// Back to back, every operation in turn
	task automatic test_streaming();
		int  k;
		int  m;
		real v;
		for (int i = 0; i < 30; i++) begin
			k = $random(seed) % 101;
			m = $random(seed) % 101;
			v = (k < 0) ? real'(k) - 0.5 : real'(k) + 0.5;
			case (i % 5)
				0: send(OP_ADD, encode_real(real'(k)), encode_real(real'(m)), '0);
				1: send(OP_MUL, encode_real(real'(k)), encode_real(real'(m)), '0);
				2: send(OP_INVSQRT, random_positive(), '0, '0);
				3: send(OP_FROM_INT, '0, '0, fp_int_t'($random(seed) % 32768));
				default: send(OP_TO_INT, encode_real(v), '0, '0);
			endcase
		end
		finish_batch();
	endtask

	initial begin
		seed      = 32'h61fa1ee3;
		reset_key = 1'b1;
		in_valid  = 1'b0;
		op        = OP_ADD;
		a         = '0;
		b         = '0;
		int_in    = '0;
		test_reset_idle();
		test_int_conversion();
		test_mul_add();
		test_invsqrt();
		test_streaming();
		// Quiet tail, no stray results
		repeat (8) @(posedge iCLK);
		$display("Checks: %0d, value errors: %0d, other errors: %0d, assertion errors: %0d",
			checks, value_errors, other_errors,
			fp_unit_inst.fp_unit_sva_inst.assert_errors);
		if (value_errors == 0 && other_errors == 0 && checks > 0 &&
				fp_unit_inst.fp_unit_sva_inst.assert_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
